//--- hw/alu_settings.svh
//////////////////////////////////////////////////////////////////////
// alu settings
// word, shift-amount and bit-count widths shared by the ALU blocks
//////////////////////////////////////////////////////////////////////

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// data word width
`define ALU_WIDTH 32

// shift amount, log2 of the word width
`define ALU_SHAMT_W 5

// bit count result, must hold the value 32
`define ALU_CNT_W 6

`endif

//--- hw/alu_pkg.sv
//////////////////////////////////////////////////////////////////////
// alu package
// operator encoding and rotation sequencer states
//////////////////////////////////////////////////////////////////////

package alu_pkg;

  // operator codes, codes above ALU_PCNT give a zero result
  typedef enum logic [4:0] {
    // adder
    ALU_ADD,
    ALU_SUB,
    // bitwise logic, the last three negate operand b
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_XNOR,
    ALU_ORN,
    ALU_ANDN,
    // shifts and two-cycle rotations
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_ROL,
    ALU_ROR,
    // set-less-than
    ALU_SLT,
    ALU_SLTU,
    // min / max
    ALU_MIN,
    ALU_MINU,
    ALU_MAX,
    ALU_MAXU,
    // bit counting
    ALU_CLZ,
    ALU_CTZ,
    ALU_PCNT
  } alu_op_e;

  // rotation sequencer
  typedef enum logic {
    ST_IDLE,
    ST_ROT2
  } alu_state_e;

endpackage

//--- hw/alu_op_if.sv
//////////////////////////////////////////////////////////////////////
// alu operation interface
// one operation from the control block into the datapath, results back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_settings.svh"

interface alu_op_if import alu_pkg::*; ();

  // operation and operands, stored copy during the second rotation cycle
  alu_op_e               op;
  logic [`ALU_WIDTH-1:0] operand_a;
  logic [`ALU_WIDTH-1:0] operand_b;
  // low only in the second rotation cycle
  logic                  first_cycle;
  // intermediate register, first rotation half
  logic [`ALU_WIDTH-1:0] imd_q;

  // datapath outputs
  logic [`ALU_WIDTH-1:0] result;
  logic [`ALU_WIDTH-1:0] imd_d;

  modport ctrl (
    output op, operand_a, operand_b, first_cycle, imd_q,
    input  result, imd_d
  );

  modport dp (
    input  op, operand_a, operand_b, first_cycle, imd_q,
    output result, imd_d
  );

endinterface

//--- hw/alu_adder_cmp.sv
//////////////////////////////////////////////////////////////////////
// alu adder and comparator
// add/sub, signed and unsigned less-than, min/max select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_adder_cmp import alu_pkg::*; (
  input  alu_op_e               op_i,
  input  logic [`ALU_WIDTH-1:0] operand_a_i,
  input  logic [`ALU_WIDTH-1:0] operand_b_i,
  output logic [`ALU_WIDTH-1:0] sum_o,
  output logic                  lt_o,
  output logic [`ALU_WIDTH-1:0] minmax_o
);

  logic                negate_b;
  logic                cmp_signed;
  logic                pick_b;
  logic [`ALU_WIDTH:0] adder_in_a;
  logic [`ALU_WIDTH:0] adder_in_b;
  logic [`ALU_WIDTH:0] adder_ext;

  // everything except add works on a - b
  assign negate_b = (op_i == ALU_SUB)  || (op_i == ALU_SLT)  || (op_i == ALU_SLTU) ||
                    (op_i == ALU_MIN)  || (op_i == ALU_MINU) ||
                    (op_i == ALU_MAX)  || (op_i == ALU_MAXU);

  assign cmp_signed = (op_i == ALU_SLT) || (op_i == ALU_MIN) || (op_i == ALU_MAX);

  // extra low bit is the carry-in, set on both sides for the two's complement +1
  assign adder_in_a = {operand_a_i, 1'b1};
  assign adder_in_b = negate_b ? {~operand_b_i, 1'b1} : {operand_b_i, 1'b0};
  assign adder_ext  = adder_in_a + adder_in_b;
  assign sum_o      = adder_ext[`ALU_WIDTH:1];

  // same top bits: sign of the difference decides
  // different top bits: negative a is less when signed, else b is the larger
  always_comb begin
    if (operand_a_i[`ALU_WIDTH-1] == operand_b_i[`ALU_WIDTH-1]) begin
      lt_o = sum_o[`ALU_WIDTH-1];
    end else if (cmp_signed) begin
      lt_o = operand_a_i[`ALU_WIDTH-1];
    end else begin
      lt_o = operand_b_i[`ALU_WIDTH-1];
    end
  end

  // min keeps a when a < b, max keeps b then
  assign pick_b   = ((op_i == ALU_MAX) || (op_i == ALU_MAXU)) ? lt_o : !lt_o;
  assign minmax_o = pick_b ? operand_b_i : operand_a_i;

endmodule

//--- hw/alu_shifter.sv
//////////////////////////////////////////////////////////////////////
// alu shifter
// 33-bit arithmetic right shifter, reversed around for left shifts
// also produces both halves of a rotation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_shifter import alu_pkg::*; (
  input  alu_op_e                 op_i,
  input  logic                    first_cycle_i,
  input  logic [`ALU_WIDTH-1:0]   operand_a_i,
  input  logic [`ALU_SHAMT_W-1:0] shamt_i,
  output logic [`ALU_WIDTH-1:0]   shift_o
);

  logic                   is_rot;
  logic                   shift_left;
  logic                   shift_arith;
  logic [`ALU_SHAMT_W-1:0] shamt_compl;
  logic [`ALU_SHAMT_W-1:0] amt;
  logic [`ALU_WIDTH-1:0]   shift_in;
  logic [`ALU_WIDTH:0]     shift_ext;
  logic [`ALU_WIDTH-1:0]   shift_res;

  assign is_rot = (op_i == ALU_ROL) || (op_i == ALU_ROR);

  // rol goes left first, ror goes left in the second cycle
  always_comb begin
    case (op_i)
      ALU_SLL: shift_left = 1'b1;
      ALU_ROL: shift_left = first_cycle_i;
      ALU_ROR: shift_left = !first_cycle_i;
      default: shift_left = 1'b0;
    endcase
  end

  assign shift_arith = (op_i == ALU_SRA);

  // 32 - amount, wraps to 0 for amount 0
  assign shamt_compl = ~shamt_i + `ALU_SHAMT_W'(1);

  // second rotation cycle uses the complement
  assign amt = (is_rot && !first_cycle_i) ? shamt_compl : shamt_i;

  // reverse the operand so a left shift runs on the right shifter
  assign shift_in = shift_left ? {<<{operand_a_i}} : operand_a_i;

  // extension bit carries the sign for sra
  assign shift_ext = $signed({shift_arith && shift_in[`ALU_WIDTH-1], shift_in}) >>> amt;

  assign shift_res = shift_ext[`ALU_WIDTH-1:0];

  // undo the reversal
  assign shift_o = shift_left ? {<<{shift_res}} : shift_res;

endmodule

//--- hw/alu_bitwise.sv
//////////////////////////////////////////////////////////////////////
// alu bitwise logic and bit counting
// xor/or/and with optional negated b, clz/ctz/pcnt
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_bitwise import alu_pkg::*; (
  input  alu_op_e               op_i,
  input  logic [`ALU_WIDTH-1:0] operand_a_i,
  input  logic [`ALU_WIDTH-1:0] operand_b_i,
  output logic [`ALU_WIDTH-1:0] logic_o,
  output logic [`ALU_CNT_W-1:0] count_o
);

  logic [`ALU_WIDTH-1:0] b_op;
  logic [`ALU_WIDTH-1:0] cnt_bits;
  logic [`ALU_WIDTH-1:0] cnt_en;
  logic                  is_pcnt;

  // one negatable copy of b for all three functions
  assign b_op = ((op_i == ALU_XNOR) || (op_i == ALU_ORN) || (op_i == ALU_ANDN)) ?
                ~operand_b_i : operand_b_i;

  always_comb begin
    case (op_i)
      ALU_OR, ALU_ORN:   logic_o = operand_a_i | b_op;
      ALU_AND, ALU_ANDN: logic_o = operand_a_i & b_op;
      default:           logic_o = operand_a_i ^ b_op;
    endcase
  end

  assign is_pcnt = (op_i == ALU_PCNT);

  // leading zeros of a are trailing ones of the inverted, reversed word
  assign cnt_bits = is_pcnt ? operand_a_i :
                    (op_i == ALU_CTZ) ? ~operand_a_i : ~{<<{operand_a_i}};

  // enable chain, breaks at the first 0 unless counting all bits
  always_comb begin
    cnt_en[0] = 1'b1;
    for (int i = 1; i < `ALU_WIDTH; i++) begin
      cnt_en[i] = is_pcnt || (cnt_en[i-1] && cnt_bits[i-1]);
    end
  end

  always_comb begin
    count_o = '0;
    for (int i = 0; i < `ALU_WIDTH; i++) begin
      count_o = count_o + `ALU_CNT_W'(cnt_en[i] && cnt_bits[i]);
    end
  end

endmodule

//--- hw/alu_datapath.sv
//////////////////////////////////////////////////////////////////////
// alu datapath
// functional units, rotation merge and result select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_datapath import alu_pkg::*; (
  alu_op_if.dp dp_if
);

  logic [`ALU_WIDTH-1:0] sum;
  logic                  lt;
  logic [`ALU_WIDTH-1:0] minmax;
  logic [`ALU_WIDTH-1:0] shift_res;
  logic [`ALU_WIDTH-1:0] logic_res;
  logic [`ALU_CNT_W-1:0] count;
  logic [`ALU_WIDTH-1:0] rot_res;

  alu_adder_cmp u_adder_cmp (
    .op_i        (dp_if.op),
    .operand_a_i (dp_if.operand_a),
    .operand_b_i (dp_if.operand_b),
    .sum_o       (sum),
    .lt_o        (lt),
    .minmax_o    (minmax)
  );

  alu_shifter u_shifter (
    .op_i          (dp_if.op),
    .first_cycle_i (dp_if.first_cycle),
    .operand_a_i   (dp_if.operand_a),
    .shamt_i       (dp_if.operand_b[`ALU_SHAMT_W-1:0]),
    .shift_o       (shift_res)
  );

  alu_bitwise u_bitwise (
    .op_i        (dp_if.op),
    .operand_a_i (dp_if.operand_a),
    .operand_b_i (dp_if.operand_b),
    .logic_o     (logic_res),
    .count_o     (count)
  );

  // first half is saved by the control block
  assign dp_if.imd_d = shift_res;

  // amount zero makes both halves equal to a, so take the saved one alone
  assign rot_res = (dp_if.operand_b[`ALU_SHAMT_W-1:0] == '0) ?
                   dp_if.imd_q : (dp_if.imd_q | shift_res);

  always_comb begin
    case (dp_if.op)
      ALU_ADD, ALU_SUB:                     dp_if.result = sum;
      ALU_XOR, ALU_OR, ALU_AND,
      ALU_XNOR, ALU_ORN, ALU_ANDN:          dp_if.result = logic_res;
      ALU_SLL, ALU_SRL, ALU_SRA:            dp_if.result = shift_res;
      ALU_ROL, ALU_ROR:                     dp_if.result = rot_res;
      ALU_SLT, ALU_SLTU:                    dp_if.result = {{(`ALU_WIDTH-1){1'b0}}, lt};
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU: dp_if.result = minmax;
      ALU_CLZ, ALU_CTZ, ALU_PCNT:
        dp_if.result = {{(`ALU_WIDTH-`ALU_CNT_W){1'b0}}, count};
      // unused codes
      default:                              dp_if.result = '0;
    endcase
  end

endmodule

//--- hw/alu_ctrl.sv
//////////////////////////////////////////////////////////////////////
// alu control
// valid/ready handshakes, rotation sequencing and the result register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_ctrl import alu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  alu_op_e               op_i,
  input  logic [`ALU_WIDTH-1:0] operand_a_i,
  input  logic [`ALU_WIDTH-1:0] operand_b_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [`ALU_WIDTH-1:0] result_o,
  alu_op_if.ctrl                dp_if
);

  alu_state_e            state_q;
  logic                  res_valid_q;
  alu_op_e               op_q;
  logic [`ALU_WIDTH-1:0] a_q;
  logic [`ALU_WIDTH-1:0] b_q;
  logic [`ALU_WIDTH-1:0] imd_val_q;
  logic [`ALU_WIDTH-1:0] res_q;

  logic in_rot2;
  logic is_rot;
  logic accept;
  logic consume;
  logic res_we;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  assign in_rot2 = (state_q == ST_ROT2);
  assign is_rot  = (op_i == ALU_ROL) || (op_i == ALU_ROR);

  // idle, and result slot free or draining this edge
  assign in_ready_o = (state_q == ST_IDLE) && (!res_valid_q || out_ready_i);
  assign accept     = in_valid_i && in_ready_o;
  assign consume    = res_valid_q && out_ready_i;

  // single-cycle ops write at accept, rotations one edge later
  assign res_we = (accept && !is_rot) || in_rot2;

  assign out_valid_o = res_valid_q;
  assign result_o    = res_q;

  // first cycle straight from the inputs, second from the stored copy
  assign dp_if.op          = in_rot2 ? op_q : op_i;
  assign dp_if.operand_a   = in_rot2 ? a_q : operand_a_i;
  assign dp_if.operand_b   = in_rot2 ? b_q : operand_b_i;
  assign dp_if.first_cycle = !in_rot2;
  assign dp_if.imd_q       = imd_val_q;

  //////////////////////////////////////////////////////////////////////
  // sequencer and registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= ST_IDLE;
      res_valid_q <= 1'b0;
    end else begin
      if (accept && is_rot) begin
        state_q <= ST_ROT2;
      end else if (in_rot2) begin
        state_q <= ST_IDLE;
      end
      // a new write wins over a same-edge consume
      if (res_we) begin
        res_valid_q <= 1'b1;
      end else if (consume) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    // keep operands and first half for the second rotation cycle
    if (accept && is_rot) begin
      op_q      <= op_i;
      a_q       <= operand_a_i;
      b_q       <= operand_b_i;
      imd_val_q <= dp_if.imd_d;
    end
    if (res_we) begin
      res_q <= dp_if.result;
    end
  end

  // held result must not move under back-pressure
  a_result_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> $stable(result_o));

  // second rotation cycle blocks input and always lands in the result register
  a_rot2_step : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_rot2 |-> !in_ready_o ##1 (state_q == ST_IDLE && out_valid_o));

endmodule

//--- hw/alu_top.sv
//////////////////////////////////////////////////////////////////////
// alu top
// registered 32-bit ALU with valid/ready on input and output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_settings.svh"

module alu_top import alu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  alu_op_e               op_i,
  input  logic [`ALU_WIDTH-1:0] operand_a_i,
  input  logic [`ALU_WIDTH-1:0] operand_b_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [`ALU_WIDTH-1:0] result_o
);

  // control to datapath, combinational both ways
  alu_op_if u_op_if ();

  alu_ctrl u_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .dp_if       (u_op_if.ctrl)
  );

  alu_datapath u_datapath (
    .dp_if (u_op_if.dp)
  );

endmodule

//--- tests/tb_alu.sv
//////////////////////////////////////////////////////////////////////
// alu testbench
// directed edge cases and LFSR-random operations under random output
// back-pressure, checked in order against a reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "alu_settings.svh"

module tb_alu import alu_pkg::*; ();

  localparam int          NUM_OPS        = 600;
  localparam int          TIMEOUT_CYCLES = NUM_OPS * 8 + 100;
  localparam logic [31:0] LFSR_SEED      = 32'd37;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  alu_op_e               op_i;
  logic [`ALU_WIDTH-1:0] operand_a_i;
  logic [`ALU_WIDTH-1:0] operand_b_i;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic [`ALU_WIDTH-1:0] result_o;

  logic [31:0] lfsr_q;

  // stimulus, built once before reset
  alu_op_e     stim_op [$];
  logic [31:0] stim_a  [$];
  logic [31:0] stim_b  [$];

  // scoreboard, one entry per accepted operation
  logic [31:0] exp_q   [$];
  string       desc_q  [$];
  int          done_count = 0;

  alu_op_e     cmp_ops   [6] = '{ALU_SLT, ALU_SLTU, ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU};
  alu_op_e     shift_ops [5] = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROL, ALU_ROR};
  alu_op_e     cnt_ops   [3] = '{ALU_CLZ, ALU_CTZ, ALU_PCNT};
  logic [31:0] edge_vals [5] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};

  alu_top u_alu_top (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // galois lfsr, one step per bit taken, msb first into the result
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // expected result straight from the operator definitions
  function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [31:0] res;
    logic [4:0]  sh;
    int          cnt;
    sh  = b[4:0];
    cnt = 0;
    case (op)
      ALU_ADD:  res = a + b;
      ALU_SUB:  res = a - b;
      ALU_XOR:  res = a ^ b;
      ALU_OR:   res = a | b;
      ALU_AND:  res = a & b;
      ALU_XNOR: res = a ^ ~b;
      ALU_ORN:  res = a | ~b;
      ALU_ANDN: res = a & ~b;
      ALU_SLL:  res = a << sh;
      ALU_SRL:  res = a >> sh;
      ALU_SRA:  res = $signed(a) >>> sh;
      // rotate by 0 leaves a as it is
      ALU_ROL:  res = (sh == 5'd0) ? a : ((a << sh) | (a >> (6'd32 - {1'b0, sh})));
      ALU_ROR:  res = (sh == 5'd0) ? a : ((a >> sh) | (a << (6'd32 - {1'b0, sh})));
      ALU_SLT:  res = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: res = {31'b0, a < b};
      ALU_MIN:  res = ($signed(a) < $signed(b)) ? a : b;
      ALU_MINU: res = (a < b) ? a : b;
      ALU_MAX:  res = ($signed(a) < $signed(b)) ? b : a;
      ALU_MAXU: res = (a < b) ? b : a;
      ALU_CLZ: begin
        for (int i = 31; i >= 0; i--) begin
          if (a[i]) break;
          cnt++;
        end
        res = 32'(cnt);
      end
      ALU_CTZ: begin
        for (int i = 0; i < 32; i++) begin
          if (a[i]) break;
          cnt++;
        end
        res = 32'(cnt);
      end
      ALU_PCNT: res = 32'($countones(a));
      default:  res = '0;
    endcase
    return res;
  endfunction

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(logic [31:0] got, logic [31:0] expected, string msg);
    if (got !== expected) begin
      $display("MISMATCH at %0t: %s, got 0x%08h, expected 0x%08h", $time, msg, got, expected);
      end_with_failure();
    end
  endtask

  task automatic add_op(alu_op_e op, logic [31:0] a, logic [31:0] b);
    stim_op.push_back(op);
    stim_a.push_back(a);
    stim_b.push_back(b);
  endtask

  task automatic build_ops();
    logic [4:0]  code;
    logic [31:0] a;
    logic [31:0] b;
    // compares and min/max over every edge pair
    foreach (cmp_ops[k]) begin
      foreach (edge_vals[i]) begin
        foreach (edge_vals[j]) begin
          add_op(cmp_ops[k], edge_vals[i], edge_vals[j]);
        end
      end
    end
    // shift amounts 0 and 31, random upper bits in b must not matter
    foreach (shift_ops[k]) begin
      a = take_bits(32);
      b = take_bits(27) << 5;
      add_op(shift_ops[k], a, b);
      a = take_bits(32);
      b = (take_bits(27) << 5) | 32'd31;
      add_op(shift_ops[k], a, b);
    end
    // counts on all zeros and all ones
    foreach (cnt_ops[k]) begin
      b = take_bits(32);
      add_op(cnt_ops[k], 32'h0, b);
      b = take_bits(32);
      add_op(cnt_ops[k], 32'hffff_ffff, b);
    end
    // random over all 22 operators
    while (stim_op.size() < NUM_OPS) begin
      code = 5'(take_bits(5) % 32'd22);
      a    = take_bits(32);
      b    = take_bits(32);
      add_op(alu_op_e'(code), a, b);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // processes
  //////////////////////////////////////////////////////////////////////

  // input driver, sequence and end of run
  initial begin : main
    arst_n_i    <= 1'b0;
    in_valid_i  <= 1'b0;
    op_i        <= ALU_ADD;
    operand_a_i <= '0;
    operand_b_i <= '0;
    lfsr_q = LFSR_SEED;
    build_ops();
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // idle and empty out of reset
    @(negedge clk_i);
    check_value({31'b0, out_valid_o}, 32'd0, "out_valid_o after reset");
    check_value({31'b0, in_ready_o}, 32'd1, "in_ready_o after reset");
    for (int i = 0; i < NUM_OPS; i++) begin
      @(posedge clk_i);
      in_valid_i  <= 1'b1;
      op_i        <= stim_op[i];
      operand_a_i <= stim_a[i];
      operand_b_i <= stim_b[i];
      // ready seen at the falling edge is what the next rising edge uses
      @(negedge clk_i);
      while (!in_ready_o) begin
        @(negedge clk_i);
      end
      exp_q.push_back(alu_ref(stim_op[i], stim_a[i], stim_b[i]));
      desc_q.push_back($sformatf("op %0d %s a=0x%08h b=0x%08h", i, stim_op[i].name(),
                                 stim_a[i], stim_b[i]));
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    wait (done_count == NUM_OPS);
    // a few idle cycles to catch a repeated result
    repeat (10) @(posedge clk_i);
    // nothing may be left in the result register
    @(negedge clk_i);
    if (!out_valid_o) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("ERROR: a result is still pending after the last operation was taken");
      end_with_failure();
    end
  end

  // random back-pressure on the output
  initial begin : ready_gen
    out_ready_i <= 1'b0;
    wait (arst_n_i);
    forever begin
      @(posedge clk_i);
      out_ready_i <= (take_bits(1) != 32'd0);
    end
  end

  // scoreboard compare, sampled at the falling edge where outputs are settled
  initial begin : compare
    logic [31:0] held_val;
    logic        held;
    logic [31:0] exp_val;
    string       desc;
    held     = 1'b0;
    held_val = '0;
    forever begin
      @(negedge clk_i);
      if (arst_n_i && out_valid_o) begin
        if (held) begin
          check_value(result_o, held_val, "held result_o changed before it was taken");
        end else begin
          held_val = result_o;
        end
        held = !out_ready_i;
        if (out_ready_i) begin
          if (exp_q.size() == 0) begin
            $display("ERROR at %0t: result 0x%08h delivered with no operation pending",
                     $time, result_o);
            end_with_failure();
          end else begin
            exp_val = exp_q.pop_front();
            desc    = desc_q.pop_front();
            check_value(result_o, exp_val, desc);
            done_count++;
          end
        end
      end
    end
  end

  // watchdog
  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("ERROR: simulation timed out after %0d cycles, %0d of %0d results seen",
                 cycles, done_count, NUM_OPS);
        end_with_failure();
      end
    end
  end

endmodule

//--- tb.f
+incdir+hw
hw/alu_pkg.sv
hw/alu_op_if.sv
hw/alu_adder_cmp.sv
hw/alu_shifter.sv
hw/alu_bitwise.sv
hw/alu_datapath.sv
hw/alu_ctrl.sv
hw/alu_top.sv
tests/tb_alu.sv

//--- run.sh
#!/usr/bin/env bash
# build the ALU testbench with Verilator and run it from the project root
# the run passes only when the pass line shows up in the simulator output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module tb_alu -o tb_alu_sim \
  && ./obj_dir/tb_alu_sim | tee /dev/stderr | grep "Test completed successfully" > /dev/null \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
